//--- Makefile
TOOL   := verilator
FLAGS  := --binary --timing
TOP    := tb_fetch_buffer
FLIST  := flist.f
BUILD  := obj_dir
LOG    := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "^>>> PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- flist.f
+incdir+include
logic/frontend_pkg.sv
logic/fetch_fifo.sv
logic/branch_predecode.sv
logic/inst_buffer.sv
logic/fetch_buffer_top.sv
test/tb_fetch_buffer.sv

//--- logic/branch_predecode.sv
`timescale 1ns/100ps

module branch_predecode (
    input  frontend_pkg::fetch_slot_t  [1:0] fetch_i,
    output frontend_pkg::branch_info_t [1:0] binfo_o,
    output logic                       [1:0] slot_cancel_o
);

    import frontend_pkg::*;

    // major opcodes, inst[31:26]
    localparam logic [5:0] op_b_c    = 6'b010100;
    localparam logic [5:0] op_bl_c   = 6'b010101;
    localparam logic [5:0] op_beq_c  = 6'b010110;
    localparam logic [5:0] op_bne_c  = 6'b010111;
    localparam logic [5:0] op_blt_c  = 6'b011000;
    localparam logic [5:0] op_bge_c  = 6'b011001;
    localparam logic [5:0] op_bltu_c = 6'b011010;
    localparam logic [5:0] op_bgeu_c = 6'b011011;

    for (genvar i = 0; i < 2; i++) begin : gen_slot
        logic [5:0]        opcode;
        logic              is_uncond;
        logic              is_cond;
        logic [xlen_c-1:0] offs16_ext;
        logic [xlen_c-1:0] offs26_ext;

        assign opcode = fetch_i[i].inst[31:26];

        always_comb begin
            is_uncond = 1'b0;
            is_cond   = 1'b0;
            case (opcode)
                op_b_c, op_bl_c: begin
                    is_uncond = 1'b1;
                end
                op_beq_c, op_bne_c, op_blt_c, op_bge_c, op_bltu_c, op_bgeu_c: begin
                    is_cond = 1'b1;
                end
                default: begin
                    is_uncond = 1'b0;
                    is_cond   = 1'b0;
                end
            endcase
        end

        // offs16 sits in inst[25:10]
        assign offs16_ext = {{14{fetch_i[i].inst[25]}}, fetch_i[i].inst[25:10], 2'b00};

        // offs26 keeps its high part in inst[9:0]
        assign offs26_ext = {{4{fetch_i[i].inst[9]}}, fetch_i[i].inst[9:0],
                             fetch_i[i].inst[25:10], 2'b00};

        always_comb begin
            binfo_o[i] = '0;
            if (is_uncond) begin
                binfo_o[i].is_branch       = 1'b1;
                binfo_o[i].pre_taken       = 1'b1;
                binfo_o[i].pre_branch_addr = fetch_i[i].pc + offs26_ext;
            end else if (is_cond) begin
                // backward taken, forward not taken
                binfo_o[i].is_branch       = 1'b1;
                binfo_o[i].pre_taken       = fetch_i[i].inst[25];
                binfo_o[i].pre_branch_addr = fetch_i[i].pc + offs16_ext;
            end
        end
    end

    assign slot_cancel_o[0] = !fetch_i[0].en;

    // slot 1 lies past a taken branch in slot 0
    assign slot_cancel_o[1] = !fetch_i[1].en ||
                              (binfo_o[0].is_branch && binfo_o[0].pre_taken);

endmodule

//--- logic/fetch_buffer_top.sv
`timescale 1ns/100ps

module fetch_buffer_top #(
    parameter int IB_DEPTH = 16
) (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             flush_i,
    input  logic                             stall_i,
    input  logic                             pause_i,

    input  frontend_pkg::fetch_slot_t  [1:0] fetch_i,
    input  frontend_pkg::tlb_exc_t     [1:0] tlb_exc_i,

    output frontend_pkg::decode_slot_t [1:0] decode_o,
    output logic                             buffer_full_o
);

    import frontend_pkg::*;

    // predecode results toward the buffer
    branch_info_t [1:0] binfo;
    logic         [1:0] slot_cancel;

    branch_predecode u_predecode (
        .fetch_i      (fetch_i),
        .binfo_o      (binfo),
        .slot_cancel_o(slot_cancel)
    );

    inst_buffer #(
        .IB_DEPTH(IB_DEPTH)
    ) u_inst_buffer (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .stall_i      (stall_i),
        .pause_i      (pause_i),
        .fetch_i      (fetch_i),
        .tlb_exc_i    (tlb_exc_i),
        .binfo_i      (binfo),
        .slot_cancel_i(slot_cancel),
        .decode_o     (decode_o),
        .buffer_full_o(buffer_full_o)
    );

endmodule

//--- logic/fetch_fifo.sv
`timescale 1ns/100ps

module fetch_fifo #(
    parameter int DEPTH = 16,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     flush_i,

    input  logic     push_i,
    input  payload_t push_data_i,

    input  logic     pop_i,
    output payload_t pop_data_o,

    output logic     full_o,
    output logic     empty_o,
    output logic     almost_full_o
);

    localparam int ptr_w_c = $clog2(DEPTH);
    localparam int cnt_w_c = ptr_w_c + 1;

    // payload storage
    payload_t mem_q [DEPTH];

    logic [ptr_w_c-1:0] wr_ptr_q;
    logic [ptr_w_c-1:0] rd_ptr_q;
    logic [cnt_w_c-1:0] count_q;

    logic push_ok;
    logic pop_ok;

    // drop push when full, pop when empty
    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o;

    assign full_o        = (count_q == cnt_w_c'(DEPTH));
    assign empty_o       = (count_q == '0);
    // fewer than two free entries
    assign almost_full_o = (count_q >= cnt_w_c'(DEPTH - 1));

    // head falls through
    assign pop_data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10: begin
                    count_q <= count_q + 1'b1;
                end
                2'b01: begin
                    count_q <= count_q - 1'b1;
                end
                default: begin
                    count_q <= count_q;
                end
            endcase
        end
    end

    // a write under flush is lost as the pointers return to zero
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

//--- logic/frontend_pkg.sv
package frontend_pkg;

    // machine word and exception cause widths
    localparam int xlen_c    = 32;
    localparam int ecode_w_c = 7;

    // one slot of the icache response
    typedef struct packed {
        logic                 en;
        logic [xlen_c-1:0]    inst;
        logic [xlen_c-1:0]    pc;
        logic                 is_exception;
        logic [ecode_w_c-1:0] exception_cause;
    } fetch_slot_t;

    // translation exception per slot from the tlb
    typedef struct packed {
        logic                 valid;
        logic [ecode_w_c-1:0] cause;
    } tlb_exc_t;

    // static prediction for one slot
    typedef struct packed {
        logic              is_branch;
        logic              pre_taken;
        logic [xlen_c-1:0] pre_branch_addr;
    } branch_info_t;

    // cache exception first, tlb exception second
    typedef struct packed {
        logic                 cache_exc;
        logic [ecode_w_c-1:0] cache_cause;
        logic                 tlb_exc;
        logic [ecode_w_c-1:0] tlb_cause;
    } exc_pair_t;

    // one entry of an instruction buffer bank
    typedef struct packed {
        exc_pair_t         exc;
        logic              valid;
        branch_info_t      binfo;
        logic [xlen_c-1:0] inst;
        logic [xlen_c-1:0] pc;
    } ib_entry_t;

    // decode stage sees the buffered entry as is
    typedef ib_entry_t decode_slot_t;

endpackage

//--- logic/inst_buffer.sv
`timescale 1ns/100ps

module inst_buffer #(
    parameter int IB_DEPTH = 16
) (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             flush_i,
    input  logic                             stall_i,
    input  logic                             pause_i,

    // from icache and tlb
    input  frontend_pkg::fetch_slot_t  [1:0] fetch_i,
    input  frontend_pkg::tlb_exc_t     [1:0] tlb_exc_i,

    // from predecode
    input  frontend_pkg::branch_info_t [1:0] binfo_i,
    input  logic                       [1:0] slot_cancel_i,

    output frontend_pkg::decode_slot_t [1:0] decode_o,
    output logic                             buffer_full_o
);

    import frontend_pkg::*;

    exc_pair_t [1:0] exc_pair;
    ib_entry_t [1:0] push_data;
    ib_entry_t [1:0] pop_data;

    logic       push_en;
    logic [1:0] pop_en;
    logic [1:0] full;
    logic [1:0] almost_full;
    logic [1:0] empty;

    // back-pressure toward the cache
    assign buffer_full_o = |(full | almost_full);

    // both banks push together so positions stay paired
    assign push_en = !stall_i && !buffer_full_o;

    for (genvar i = 0; i < 2; i++) begin : gen_bank

        always_comb begin
            exc_pair[i].cache_exc   = fetch_i[i].is_exception;
            exc_pair[i].cache_cause = fetch_i[i].exception_cause;
            exc_pair[i].tlb_exc     = tlb_exc_i[i].valid;
            exc_pair[i].tlb_cause   = tlb_exc_i[i].cause;
        end

        // cancelled slots still take a bank position
        always_comb begin
            if (slot_cancel_i[i]) begin
                push_data[i] = '0;
            end else begin
                push_data[i].exc   = exc_pair[i];
                push_data[i].valid = 1'b1;
                push_data[i].binfo = binfo_i[i];
                push_data[i].inst  = fetch_i[i].inst;
                push_data[i].pc    = fetch_i[i].pc;
            end
        end

        assign pop_en[i] = !pause_i && !empty[i];

        // nothing popped, nothing valid shown
        always_comb begin
            if (pop_en[i]) begin
                decode_o[i] = pop_data[i];
            end else begin
                decode_o[i] = '0;
            end
        end

        fetch_fifo #(
            .DEPTH    (IB_DEPTH),
            .payload_t(ib_entry_t)
        ) u_bank (
            .clk          (clk),
            .reset_i      (reset_i),
            .flush_i      (flush_i),
            .push_i       (push_en),
            .push_data_i  (push_data[i]),
            .pop_i        (pop_en[i]),
            .pop_data_o   (pop_data[i]),
            .full_o       (full[i]),
            .empty_o      (empty[i]),
            .almost_full_o(almost_full[i])
        );
    end

endmodule

//--- include/tb_fetch_model.svh
`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

// expected bank contents with the head at index 0
ib_entry_t bank0_q[$];
ib_entry_t bank1_q[$];

// static prediction straight from the isa rules
function automatic branch_info_t ref_predict(logic [31:0] inst, logic [31:0] pc);
    branch_info_t bi;
    logic [5:0]   op;
    int           offs;
    bi   = '0;
    op   = inst[31:26];
    offs = 0;
    if (op == 6'h14 || op == 6'h15) begin
        // b and bl are always taken
        offs         = int'(signed'({inst[9:0], inst[25:10]}));
        bi.is_branch = 1'b1;
        bi.pre_taken = 1'b1;
    end else if (op >= 6'h16 && op <= 6'h1b) begin
        offs         = int'(signed'(inst[25:10]));
        bi.is_branch = 1'b1;
        bi.pre_taken = (offs < 0);
    end
    if (bi.is_branch) begin
        bi.pre_branch_addr = pc + 32'(offs * 4);
    end
    return bi;
endfunction

function automatic ib_entry_t ref_pack(fetch_slot_t s, tlb_exc_t t, logic cancel);
    ib_entry_t e;
    e = '0;
    if (!cancel) begin
        e.exc.cache_exc   = s.is_exception;
        e.exc.cache_cause = s.exception_cause;
        e.exc.tlb_exc     = t.valid;
        e.exc.tlb_cause   = t.cause;
        e.valid           = 1'b1;
        e.binfo           = ref_predict(s.inst, s.pc);
        e.inst            = s.inst;
        e.pc              = s.pc;
    end
    return e;
endfunction

function automatic logic expected_full();
    return (bank0_q.size() >= ib_depth_c - 1) || (bank1_q.size() >= ib_depth_c - 1);
endfunction

// what decode should see from one bank this cycle
function automatic ib_entry_t expected_head(int bank);
    ib_entry_t e;
    e = '0;
    if (!pause_i && bank == 0 && bank0_q.size() > 0) begin
        e = bank0_q[0];
    end
    if (!pause_i && bank == 1 && bank1_q.size() > 0) begin
        e = bank1_q[0];
    end
    return e;
endfunction

// advance the model by one clock edge using the current inputs
function automatic void step_banks();
    logic         push;
    logic         cancel1;
    branch_info_t b0;
    push = !stall_i && !expected_full();
    if (reset_i || flush_i) begin
        bank0_q.delete();
        bank1_q.delete();
    end else begin
        if (!pause_i && bank0_q.size() > 0) begin
            void'(bank0_q.pop_front());
        end
        if (!pause_i && bank1_q.size() > 0) begin
            void'(bank1_q.pop_front());
        end
        if (push) begin
            b0      = ref_predict(fetch_i[0].inst, fetch_i[0].pc);
            cancel1 = !fetch_i[1].en || (b0.is_branch && b0.pre_taken);
            bank0_q.push_back(ref_pack(fetch_i[0], tlb_exc_i[0], !fetch_i[0].en));
            bank1_q.push_back(ref_pack(fetch_i[1], tlb_exc_i[1], cancel1));
        end
    end
endfunction

`endif

//--- test/tb_fetch_buffer.sv
`timescale 1ns/100ps

module tb_fetch_buffer;

    import frontend_pkg::*;

    localparam int ib_depth_c = 16;

    logic                   clk;
    logic                   reset_i;
    logic                   flush_i;
    logic                   stall_i;
    logic                   pause_i;
    fetch_slot_t      [1:0] fetch_i;
    tlb_exc_t         [1:0] tlb_exc_i;
    decode_slot_t     [1:0] decode_o;
    logic                   buffer_full_o;

    integer      seed;
    logic [31:0] pc_next;

    `include "tb_fetch_model.svh"

    fetch_buffer_top #(
        .IB_DEPTH(ib_depth_c)
    ) i_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .stall_i      (stall_i),
        .pause_i      (pause_i),
        .fetch_i      (fetch_i),
        .tlb_exc_i    (tlb_exc_i),
        .decode_o     (decode_o),
        .buffer_full_o(buffer_full_o)
    );

    always #50 clk = ~clk;

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(string what, logic [127:0] actual, logic [127:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                $time, what, actual, expected));
        end
    endtask

    // sample mid-cycle, then let the model take the coming edge
    always @(negedge clk) begin
        if (!reset_i) begin
            check_value("decode slot 0", 128'(decode_o[0]), 128'(expected_head(0)));
            check_value("decode slot 1", 128'(decode_o[1]), 128'(expected_head(1)));
            check_value("buffer_full_o", 128'(buffer_full_o), 128'(expected_full()));
        end
        step_banks();
    end

    task automatic drive_cycle(fetch_slot_t s0, fetch_slot_t s1, tlb_exc_t t0, tlb_exc_t t1);
        fetch_i[0]   = s0;
        fetch_i[1]   = s1;
        tlb_exc_i[0] = t0;
        tlb_exc_i[1] = t1;
        @(posedge clk);
        #10;
    endtask

    function automatic logic [31:0] plain_inst();
        logic [31:0] r;
        r = $random(seed);
        // opcodes below 6'h10 are never branches
        return {2'b00, r[29:0]};
    endfunction

    function automatic logic [31:0] cond_inst(logic [5:0] op, logic [15:0] offs16);
        return {op, offs16, 10'h0a5};
    endfunction

    function automatic logic [31:0] uncond_inst(logic [5:0] op, logic [25:0] offs26);
        return {op, offs26[15:0], offs26[25:16]};
    endfunction

    task automatic offer_pair(logic [31:0] inst0, logic [31:0] inst1);
        fetch_slot_t s0;
        fetch_slot_t s1;
        s0      = '{en: 1'b1, inst: inst0, pc: pc_next, is_exception: 1'b0,
                    exception_cause: 7'h00};
        s1      = '{en: 1'b1, inst: inst1, pc: pc_next + 32'd4, is_exception: 1'b0,
                    exception_cause: 7'h00};
        pc_next = pc_next + 32'd8;
        drive_cycle(s0, s1, '0, '0);
    endtask

    task automatic send_plain(int n);
        for (int i = 0; i < n; i++) begin
            offer_pair(plain_inst(), plain_inst());
        end
    endtask

    task automatic send_branches(int n);
        logic [31:0] r;
        logic [31:0] body0;
        logic [31:0] body1;
        logic [5:0]  op0;
        logic [5:0]  op1;
        for (int i = 0; i < n; i++) begin
            r     = $random(seed);
            body0 = plain_inst();
            body1 = plain_inst();
            op0   = 6'h14 + {3'b000, r[2:0]};
            op1   = 6'h14 + {3'b000, r[5:3]};
            if (r[6]) begin
                offer_pair({op0, body0[25:0]}, {op1, body1[25:0]});
            end else begin
                offer_pair(body0, {op1, body1[25:0]});
            end
        end
    endtask

    // disabled slots, cache and tlb exceptions
    task automatic send_mixed(int n);
        logic [31:0] r;
        fetch_slot_t s0;
        fetch_slot_t s1;
        tlb_exc_t    t0;
        tlb_exc_t    t1;
        for (int i = 0; i < n; i++) begin
            r       = $random(seed);
            s0      = '{en: r[0], inst: plain_inst(), pc: pc_next, is_exception: r[1],
                        exception_cause: r[8:2]};
            s1      = '{en: r[16], inst: plain_inst(), pc: pc_next + 32'd4,
                        is_exception: r[17], exception_cause: r[24:18]};
            t0      = '{valid: r[9], cause: r[15:9]};
            t1      = '{valid: r[25], cause: r[31:25]};
            pc_next = pc_next + 32'd8;
            drive_cycle(s0, s1, t0, t1);
        end
    endtask

    task automatic wait_for_full(int limit);
        int cycles;
        cycles = 0;
        while (!buffer_full_o) begin
            if (cycles == limit) begin
                abort_run("timeout: buffer_full_o did not rise while decode was paused");
            end
            offer_pair(plain_inst(), plain_inst());
            cycles++;
        end
    endtask

    // hold the source off and let decode empty both banks
    task automatic wait_for_drain(int limit);
        int cycles;
        cycles  = 0;
        stall_i = 1'b1;
        pause_i = 1'b0;
        while (bank0_q.size() > 0 || bank1_q.size() > 0) begin
            if (cycles == limit) begin
                abort_run("timeout: the instruction buffer did not drain");
            end
            @(posedge clk);
            #10;
            cycles++;
        end
        stall_i = 1'b0;
    endtask

    initial begin
        seed          = 32'h0a03b481;
        pc_next       = 32'h1c00_0000;
        clk           = 1'b0;
        reset_i       = 1'b1;
        flush_i       = 1'b0;
        stall_i       = 1'b0;
        pause_i       = 1'b0;
        fetch_i       = '0;
        tlb_exc_i     = '0;
        repeat (16) @(posedge clk);
        #10;
        reset_i = 1'b0;

        // plain stream
        send_plain(20);

        // backward taken cond in slot 0 cancels slot 1
        offer_pair(cond_inst(6'h16, 16'hfff0), plain_inst());
        offer_pair(cond_inst(6'h17, 16'h0040), cond_inst(6'h18, 16'h8000));
        offer_pair(cond_inst(6'h19, 16'h7fff), cond_inst(6'h1a, 16'hffff));
        offer_pair(cond_inst(6'h1b, 16'h0001), plain_inst());
        offer_pair(uncond_inst(6'h14, 26'h0000100), plain_inst());
        offer_pair(plain_inst(), uncond_inst(6'h15, 26'h3ffff00));
        offer_pair(uncond_inst(6'h15, 26'h2000000), plain_inst());
        send_branches(24);

        send_mixed(24);

        // back-pressure
        pause_i = 1'b1;
        wait_for_full(2 * ib_depth_c + 8);
        send_plain(4);
        check_value("buffer_full_o under pause", 128'(buffer_full_o), 128'(1));
        wait_for_drain(2 * ib_depth_c + 8);

        // stall blocks pushes
        stall_i = 1'b1;
        send_plain(6);
        check_value("decode slot 0 valid under stall", 128'(decode_o[0].valid), 128'(0));
        check_value("decode slot 1 valid under stall", 128'(decode_o[1].valid), 128'(0));
        stall_i = 1'b0;

        // flush mid-stream with a push in the same cycle
        pause_i = 1'b1;
        send_plain(5);
        flush_i = 1'b1;
        offer_pair(plain_inst(), plain_inst());
        flush_i = 1'b0;
        pause_i = 1'b0;
        send_plain(8);
        wait_for_drain(2 * ib_depth_c + 8);
        send_mixed(4);
        wait_for_drain(2 * ib_depth_c + 8);

        $display(">>> PASS");
        $finish;
    end

endmodule
